/* Makefile */
# Verilator build and run of the array heap testbench

VERILATOR ?= verilator
TOP       ?= arrayHeapTb
FILELIST  ?= arrayHeap.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* arrayHeap.f */
+incdir+logic
logic/arrayHeapPkg.sv
logic/heapDecode.sv
logic/heapExecute.sv
logic/heapResult.sv
logic/arrayHeap.sv
verification/arrayHeapTb.sv

/* logic/arrayHeap.sv */
//----------------------------------------
// Array heap with a Wishbone classic
// slave port, decode/execute/result
//----------------------------------------
`include "arrayHeap_cfg.svh"

module arrayHeap (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [`HEAP_ADDR_BITS-1:0] adr,
  input  logic [`HEAP_DATA_BITS-1:0] writeData,
  output logic [`HEAP_DATA_BITS-1:0] readData,
  output logic                       ack,
  output logic                       err
);

  arrayHeapPkg::heapCommand command;                        // Decode to execute
  arrayHeapPkg::heapResult  result;                         // Execute to response
  logic                     done;                           // Response back to decode

  heapDecode decode0 (
    .clock     (clock),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .writeData (writeData),
    .done      (done),
    .command   (command)
  );

  heapExecute execute0 (
    .clock   (clock),
    .reset   (reset),
    .command (command),
    .result  (result)
  );

  heapResult result0 (
    .clock    (clock),
    .reset    (reset),
    .result   (result),
    .readData (readData),
    .ack      (ack),
    .err      (err),
    .done     (done)
  );

endmodule

/* logic/arrayHeapPkg.sv */
//----------------------------------------
// Operation and error codes, plus the
// command and result words between stages
//----------------------------------------
`include "arrayHeap_cfg.svh"

package arrayHeapPkg;

  typedef enum logic [`HEAP_OP_BITS-1:0] {
    opAlloc,                                                // Hand out a free array
    opFree,                                                 // Return an array to the free stack
    opWrite,                                                // Store operand at index
    opRead,                                                 // Fetch element at index
    opSize,                                                 // Current element count
    opPush,                                                 // Append operand
    opPop,                                                  // Remove last element
    opAdd,
    opAddAfter,                                             // Returns the old value
    opSubtract,
    opSubAfter,                                             // Returns the old value
    opOr,
    opXor,
    opAnd,
    opNot                                                   // Operand ignored
  } heapOp;

  typedef enum logic [3:0] {
    errNone,
    errBadOp,                                               // Unknown code or read cycle
    errNotAllocated,
    errFreed,                                               // Also flags a double free
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } heapError;

  typedef struct packed {
    logic                        valid;
    heapOp                       op;
    logic [`HEAP_ARRAY_BITS-1:0] array;
    logic [`HEAP_INDEX_BITS-1:0] index;
    logic [`HEAP_DATA_BITS-1:0]  operand;
    logic                        badOp;
  } heapCommand;

  typedef struct packed {
    logic                       valid;
    heapError                   error;
    logic [`HEAP_DATA_BITS-1:0] data;
  } heapResult;

endpackage

/* logic/arrayHeap_cfg.svh */
//----------------------------------------
// Array heap widths and the layout of
// the command address word
//----------------------------------------
`ifndef ARRAYHEAP_CFG_SVH
`define ARRAYHEAP_CFG_SVH

`define HEAP_ARRAY_BITS 3                                   // Eight arrays
`define HEAP_INDEX_BITS 3                                   // Eight elements per array
`define HEAP_DATA_BITS  16                                  // Element and bus data width
`define HEAP_OP_BITS    5                                   // Operation code width

// Address word is op, then array, then index in the low bits
`define HEAP_ADDR_BITS  (`HEAP_OP_BITS + `HEAP_ARRAY_BITS + `HEAP_INDEX_BITS)
`define HEAP_INDEX_LSB  0
`define HEAP_ARRAY_LSB  (`HEAP_INDEX_BITS)
`define HEAP_OP_LSB     (`HEAP_ARRAY_BITS + `HEAP_INDEX_BITS)

`endif

/* logic/heapDecode.sv */
//----------------------------------------
// Bus cycle capture and command decode
//----------------------------------------
`include "arrayHeap_cfg.svh"

module heapDecode (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [`HEAP_ADDR_BITS-1:0] adr,
  input  logic [`HEAP_DATA_BITS-1:0] writeData,
  input  logic                       done,
  output arrayHeapPkg::heapCommand   command
);

  logic                     busy;                           // Command in flight
  logic                     accept;
  logic [`HEAP_OP_BITS-1:0] opCode;
  logic                     knownOp;

  assign accept  = cyc && stb && !busy;
  assign opCode  = adr[`HEAP_OP_LSB +: `HEAP_OP_BITS];
  assign knownOp = opCode <= `HEAP_OP_BITS'(arrayHeapPkg::opNot); // Codes are dense from zero

  // Busy runs from acceptance until the response stage reports done.
  // Done is seen one edge after ack, so the held stb of the finished
  // cycle is never taken as a new request.
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      busy <= 1'b0;
    end else if (done) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end
  end

  //----------------------------------------
  // Command register
  //----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      command <= '0;
    end else begin
      command.valid <= accept;                              // One-cycle pulse
      if (accept) begin
        command.op      <= arrayHeapPkg::heapOp'(opCode);
        command.array   <= adr[`HEAP_ARRAY_LSB +: `HEAP_ARRAY_BITS];
        command.index   <= adr[`HEAP_INDEX_LSB +: `HEAP_INDEX_BITS];
        command.operand <= writeData;
        command.badOp   <= !we || !knownOp;                 // All commands are writes
      end
    end
  end

endmodule

/* logic/heapExecute.sv */
//----------------------------------------
// Element storage, sizes and allocator
// Checks each command, then updates state
//----------------------------------------
`include "arrayHeap_cfg.svh"

module heapExecute (
  input  logic                     clock,
  input  logic                     reset,
  input  arrayHeapPkg::heapCommand command,
  output arrayHeapPkg::heapResult  result
);

  localparam int arrayCount  = 1 << `HEAP_ARRAY_BITS;
  localparam int arrayLength = 1 << `HEAP_INDEX_BITS;
  localparam int sizeBits    = `HEAP_INDEX_BITS + 1;        // Holds 0 to arrayLength
  localparam int stackBits   = `HEAP_ARRAY_BITS + 1;

  logic [`HEAP_DATA_BITS-1:0]  memory [arrayCount][arrayLength];
  logic [sizeBits-1:0]         sizes [arrayCount];
  logic [arrayCount-1:0]       allocated;                   // In use now
  logic [arrayCount-1:0]       freed;                       // Released and not yet reused
  logic [`HEAP_ARRAY_BITS-1:0] freeStack [arrayCount];
  logic [stackBits-1:0]        stackTop;
  logic [stackBits-1:0]        nextNew;                     // Never-used arrays start here

  logic [sizeBits-1:0]         size;
  logic [sizeBits-1:0]         sizeBelow;
  logic [sizeBits-1:0]         indexNext;
  logic [stackBits-1:0]        stackBelow;
  logic [`HEAP_ARRAY_BITS-1:0] allocArray;
  logic [`HEAP_DATA_BITS-1:0]  element;
  logic [`HEAP_DATA_BITS-1:0]  updated;
  logic [`HEAP_DATA_BITS-1:0]  resultData;
  arrayHeapPkg::heapError      checkedError;
  logic                        update;

  assign size       = sizes[command.array];
  assign sizeBelow  = size - 1'b1;
  assign indexNext  = {1'b0, command.index} + 1'b1;
  assign stackBelow = stackTop - 1'b1;
  assign allocArray = (stackTop != '0) ? freeStack[stackBelow[`HEAP_ARRAY_BITS-1:0]]
                                       : nextNew[`HEAP_ARRAY_BITS-1:0]; // Reuse first
  assign element    = memory[command.array][command.index];
  assign update     = command.valid && checkedError == arrayHeapPkg::errNone;

  //----------------------------------------
  // Checks, in priority order
  //----------------------------------------
  always_comb begin
    checkedError = arrayHeapPkg::errNone;
    if (command.badOp) begin
      checkedError = arrayHeapPkg::errBadOp;
    end else if (command.op == arrayHeapPkg::opAlloc) begin
      if (stackTop == '0 && nextNew == stackBits'(arrayCount)) begin
        checkedError = arrayHeapPkg::errOutOfMemory;
      end
    end else if (freed[command.array]) begin
      checkedError = arrayHeapPkg::errFreed;
    end else if (!allocated[command.array]) begin
      checkedError = arrayHeapPkg::errNotAllocated;
    end else begin
      case (command.op)
        arrayHeapPkg::opPush: begin
          if (size == sizeBits'(arrayLength)) checkedError = arrayHeapPkg::errFull;
        end
        arrayHeapPkg::opPop: begin
          if (size == '0) checkedError = arrayHeapPkg::errEmpty;
        end
        arrayHeapPkg::opFree, arrayHeapPkg::opWrite, arrayHeapPkg::opSize: begin
        end
        default: begin                                      // Read and element updates
          if ({1'b0, command.index} >= size) checkedError = arrayHeapPkg::errOutOfBounds;
        end
      endcase
    end
  end

  always_comb begin
    case (command.op)
      arrayHeapPkg::opAdd, arrayHeapPkg::opAddAfter:      updated = element + command.operand;
      arrayHeapPkg::opSubtract, arrayHeapPkg::opSubAfter: updated = element - command.operand;
      arrayHeapPkg::opOr:  updated = element | command.operand;
      arrayHeapPkg::opXor: updated = element ^ command.operand;
      arrayHeapPkg::opAnd: updated = element & command.operand;
      arrayHeapPkg::opNot: updated = ~element;
      default:             updated = element;
    endcase
  end

  always_comb begin
    case (command.op)
      arrayHeapPkg::opAlloc:                        resultData = `HEAP_DATA_BITS'(allocArray);
      arrayHeapPkg::opFree:                         resultData = `HEAP_DATA_BITS'(command.array);
      arrayHeapPkg::opWrite, arrayHeapPkg::opPush:  resultData = command.operand;
      arrayHeapPkg::opRead:                         resultData = element;
      arrayHeapPkg::opSize:                         resultData = `HEAP_DATA_BITS'(size);
      arrayHeapPkg::opPop: resultData = memory[command.array][sizeBelow[`HEAP_INDEX_BITS-1:0]];
      arrayHeapPkg::opAddAfter, arrayHeapPkg::opSubAfter: resultData = element; // Old value
      default:                                      resultData = updated;
    endcase
  end

  //----------------------------------------
  // Allocator state and result register
  //----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated <= '0;
      freed     <= '0;
      stackTop  <= '0;
      nextNew   <= '0;
      result    <= '0;
    end else begin
      result.valid <= command.valid;
      result.error <= checkedError;
      result.data  <= resultData;
      if (update && command.op == arrayHeapPkg::opAlloc) begin
        allocated[allocArray] <= 1'b1;
        freed[allocArray]     <= 1'b0;
        if (stackTop != '0) stackTop <= stackBelow;
        else nextNew <= nextNew + 1'b1;
      end else if (update && command.op == arrayHeapPkg::opFree) begin
        allocated[command.array] <= 1'b0;
        freed[command.array]     <= 1'b1;
        stackTop                 <= stackTop + 1'b1;
      end
    end
  end

  // Storage, sizes and stack entries
  always_ff @(posedge clock) begin
    if (update) begin
      case (command.op)
        arrayHeapPkg::opAlloc: sizes[allocArray] <= '0; // Fresh array starts empty
        arrayHeapPkg::opFree:  freeStack[stackTop[`HEAP_ARRAY_BITS-1:0]] <= command.array;
        arrayHeapPkg::opWrite: begin
          memory[command.array][command.index] <= command.operand;
          if (indexNext > size) sizes[command.array] <= indexNext;
        end
        arrayHeapPkg::opPush: begin
          memory[command.array][size[`HEAP_INDEX_BITS-1:0]] <= command.operand;
          sizes[command.array] <= size + 1'b1;
        end
        arrayHeapPkg::opPop:  sizes[command.array] <= sizeBelow;
        arrayHeapPkg::opRead, arrayHeapPkg::opSize: begin
        end
        default: memory[command.array][command.index] <= updated; // Element updates
      endcase
    end
  end

endmodule

/* logic/heapResult.sv */
//----------------------------------------
// Bus response: ack with data or err
// with the error code
//----------------------------------------
`include "arrayHeap_cfg.svh"

module heapResult (
  input  logic                       clock,
  input  logic                       reset,
  input  arrayHeapPkg::heapResult    result,
  output logic [`HEAP_DATA_BITS-1:0] readData,
  output logic                       ack,
  output logic                       err,
  output logic                       done
);

  logic failed;

  assign failed = result.error != arrayHeapPkg::errNone;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      ack  <= 1'b0;
      err  <= 1'b0;
      done <= 1'b0;
    end else begin
      ack  <= result.valid && !failed;                      // Exactly one of ack or err
      err  <= result.valid && failed;
      done <= result.valid;                                 // Releases decode
    end
  end

  // Held until the next response
  always_ff @(posedge clock) begin
    if (result.valid) begin
      readData <= failed ? `HEAP_DATA_BITS'(result.error) : result.data;
    end
  end

endmodule

/* verification/arrayHeapTb.sv */
//----------------------------------------
// Array heap testbench: clock, reset,
// bus tasks, compare tasks, directed tests
//----------------------------------------
`include "arrayHeap_cfg.svh"

module arrayHeapTb;

  localparam int responseTimeout = 20;                      // Cycles before giving up
  localparam int responseLatency = 3;                       // Edges from drive to ack

  logic                       clock;
  logic                       reset;
  logic                       cyc;
  logic                       stb;
  logic                       we;
  logic [`HEAP_ADDR_BITS-1:0] adr;
  logic [`HEAP_DATA_BITS-1:0] writeData;
  logic [`HEAP_DATA_BITS-1:0] readData;
  logic                       ack;
  logic                       err;

  arrayHeap dut0 (
    .clock     (clock),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .writeData (writeData),
    .readData  (readData),
    .ack       (ack),
    .err       (err)
  );

  always #4 clock = ~clock;                                 // Period 8

  //----------------------------------------
  // Failure reporting and compare tasks
  //----------------------------------------
  task automatic stopOnError(input string message);
    $display("** Error at time %0t: %s", $time, message);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping after a failed check");
  endtask

  task automatic stopOnFault(input string message);
    $display("%s", message);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic checkData(input logic [`HEAP_DATA_BITS-1:0] got,
                           input logic [`HEAP_DATA_BITS-1:0] expected, input string what);
    if (got !== expected) begin
      stopOnError($sformatf("%s: got 0x%04h, expected 0x%04h", what, got, expected));
    end
  endtask

  task automatic checkError(input arrayHeapPkg::heapError got,
                            input arrayHeapPkg::heapError expected, input string what);
    if (got !== expected) begin
      stopOnError($sformatf("%s: got %s, expected %s", what, got.name(), expected.name()));
    end
  endtask

  task automatic compareLatency(input int got, input int expected, input string what);
    if (got != expected) begin
      stopOnError($sformatf("%s: got %0d cycles, expected %0d", what, got, expected));
    end
  endtask

  //----------------------------------------
  // Bus access
  //----------------------------------------
  // Called a small delay after a rising edge, returns at the same point
  task automatic busCommand(input logic [`HEAP_OP_BITS-1:0] opCode,
                            input logic [`HEAP_ARRAY_BITS-1:0] array,
                            input logic [`HEAP_INDEX_BITS-1:0] index,
                            input logic [`HEAP_DATA_BITS-1:0] operand, input logic write,
                            output logic [`HEAP_DATA_BITS-1:0] data,
                            output arrayHeapPkg::heapError status);
    int cycles;
    cyc       = 1'b1;
    stb       = 1'b1;
    we        = write;
    adr       = {opCode, array, index};
    writeData = operand;
    cycles    = 0;
    do begin
      @(posedge clock);
      #1;
      cycles++;
    end while (!ack && !err && cycles < responseTimeout);
    if (!ack && !err) stopOnFault("No ack or err from the DUT within the timeout");
    if (ack && err) stopOnFault("The DUT raised ack and err in the same cycle");
    compareLatency(cycles, responseLatency, "response latency");
    data   = readData;
    status = err ? arrayHeapPkg::heapError'(readData[3:0]) : arrayHeapPkg::errNone;
    if (err) checkData(readData, `HEAP_DATA_BITS'(status), "zero-extended error code");
    cyc = 1'b0;
    stb = 1'b0;                                             // Gap of one cycle
    we  = 1'b0;
    @(posedge clock);
    #1;
    if (ack || err) stopOnFault("ack or err stayed high for more than one cycle");
  endtask

  task automatic expectValue(input logic [`HEAP_OP_BITS-1:0] opCode,
                             input logic [`HEAP_ARRAY_BITS-1:0] array,
                             input logic [`HEAP_INDEX_BITS-1:0] index,
                             input logic [`HEAP_DATA_BITS-1:0] operand,
                             input logic [`HEAP_DATA_BITS-1:0] expected, input string what);
    logic [`HEAP_DATA_BITS-1:0] data;
    arrayHeapPkg::heapError     status;
    busCommand(opCode, array, index, operand, 1'b1, data, status);
    checkError(status, arrayHeapPkg::errNone, what);
    checkData(data, expected, what);
  endtask

  task automatic expectFault(input logic [`HEAP_OP_BITS-1:0] opCode,
                             input logic [`HEAP_ARRAY_BITS-1:0] array,
                             input logic [`HEAP_INDEX_BITS-1:0] index, input logic write,
                             input arrayHeapPkg::heapError expected, input string what);
    logic [`HEAP_DATA_BITS-1:0] data;
    arrayHeapPkg::heapError     status;
    busCommand(opCode, array, index, 16'h5a5a, write, data, status);
    checkError(status, expected, what);
  endtask

  // Reference for the element updates
  function automatic logic [`HEAP_DATA_BITS-1:0] updateModel(input arrayHeapPkg::heapOp op,
      input logic [`HEAP_DATA_BITS-1:0] old, input logic [`HEAP_DATA_BITS-1:0] operand);
    case (op)
      arrayHeapPkg::opAdd, arrayHeapPkg::opAddAfter:      return old + operand;
      arrayHeapPkg::opSubtract, arrayHeapPkg::opSubAfter: return old - operand;
      arrayHeapPkg::opOr:  return old | operand;
      arrayHeapPkg::opXor: return old ^ operand;
      arrayHeapPkg::opAnd: return old & operand;
      arrayHeapPkg::opNot: return ~old;
      default:             return old;
    endcase
  endfunction

  //----------------------------------------
  // Directed tests
  //----------------------------------------
  task automatic allocOrder();
    if (ack || err) stopOnFault("ack or err was high right after reset");
    for (int i = 0; i < 3; i++) begin
      expectValue(arrayHeapPkg::opAlloc, 0, 0, 0, `HEAP_DATA_BITS'(i), "alloc order");
    end
  endtask

  task automatic writeAndRead();
    logic [`HEAP_DATA_BITS-1:0] value;
    value = `HEAP_DATA_BITS'($urandom);
    expectValue(arrayHeapPkg::opWrite, 0, 5, value, value, "write index 5");
    expectValue(arrayHeapPkg::opSize, 0, 0, 0, 16'd6, "size after write");
    expectValue(arrayHeapPkg::opRead, 0, 5, 0, value, "read index 5");
    expectFault(arrayHeapPkg::opRead, 0, 6, 1'b1, arrayHeapPkg::errOutOfBounds, "read index 6");
  endtask

  task automatic pushAndPop();
    logic [`HEAP_DATA_BITS-1:0] pushed [8];
    for (int i = 0; i < 8; i++) begin
      pushed[i] = `HEAP_DATA_BITS'($urandom);
      expectValue(arrayHeapPkg::opPush, 1, 0, pushed[i], pushed[i], "push");
    end
    expectFault(arrayHeapPkg::opPush, 1, 0, 1'b1, arrayHeapPkg::errFull, "push to full array");
    for (int i = 7; i >= 0; i--) begin
      expectValue(arrayHeapPkg::opPop, 1, 0, 0, pushed[i], "pop order");
    end
    expectFault(arrayHeapPkg::opPop, 1, 0, 1'b1, arrayHeapPkg::errEmpty, "pop from empty array");
  endtask

  task automatic elementUpdates();
    arrayHeapPkg::heapOp        ops [8];
    logic [`HEAP_DATA_BITS-1:0] model;
    logic [`HEAP_DATA_BITS-1:0] operand;
    logic [`HEAP_DATA_BITS-1:0] fresh;
    logic                       after;
    ops = '{arrayHeapPkg::opAdd, arrayHeapPkg::opAddAfter, arrayHeapPkg::opSubtract,
            arrayHeapPkg::opSubAfter, arrayHeapPkg::opOr, arrayHeapPkg::opXor,
            arrayHeapPkg::opAnd, arrayHeapPkg::opNot};
    model = `HEAP_DATA_BITS'($urandom);
    expectValue(arrayHeapPkg::opWrite, 2, 3, model, model, "seed element");
    for (int round = 0; round < 2; round++) begin
      for (int k = 0; k < 8; k++) begin
        operand = `HEAP_DATA_BITS'($urandom);
        fresh   = updateModel(ops[k], model, operand);
        after   = ops[k] == arrayHeapPkg::opAddAfter || ops[k] == arrayHeapPkg::opSubAfter;
        expectValue(ops[k], 2, 3, operand, after ? model : fresh, ops[k].name());
        model = fresh;
      end
    end
    expectValue(arrayHeapPkg::opRead, 2, 3, 0, model, "stored after updates");
  endtask

  task automatic freeListFaults();
    expectValue(arrayHeapPkg::opFree, 1, 0, 0, 16'd1, "free array 1");
    expectValue(arrayHeapPkg::opAlloc, 0, 0, 0, 16'd1, "reuse of array 1");
    expectValue(arrayHeapPkg::opFree, 2, 0, 0, 16'd2, "free array 2");
    expectFault(arrayHeapPkg::opRead, 2, 0, 1'b1, arrayHeapPkg::errFreed, "read freed array");
    expectFault(arrayHeapPkg::opFree, 2, 0, 1'b1, arrayHeapPkg::errFreed, "double free");
    expectFault(arrayHeapPkg::opRead, 7, 0, 1'b1, arrayHeapPkg::errNotAllocated, "unallocated");
    for (int i = 2; i < 8; i++) begin                       // Stack entry, then new arrays
      expectValue(arrayHeapPkg::opAlloc, 0, 0, 0, `HEAP_DATA_BITS'(i), "alloc to full heap");
    end
    expectValue(arrayHeapPkg::opSize, 2, 0, 0, 16'd0, "size of reused array 2");
    expectFault(arrayHeapPkg::opAlloc, 0, 0, 1'b1, arrayHeapPkg::errOutOfMemory, "heap full");
    expectFault(5'd31, 0, 0, 1'b1, arrayHeapPkg::errBadOp, "undefined operation");
    expectFault(arrayHeapPkg::opRead, 0, 5, 1'b0, arrayHeapPkg::errBadOp, "read cycle");
  endtask

  initial begin
    clock     = 1'b0;
    reset     = 1'b0;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = '0;
    writeData = '0;
    void'($urandom(93));                                    // Fixed seed
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b1;
    allocOrder();
    writeAndRead();
    pushAndPop();
    elementUpdates();
    freeListFaults();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
